/* sim.f */
hdl/core_types_pkg.sv
hdl/dbg_cfg_pkg.sv
hdl/bp_regs.sv
hdl/bp_match.sv
hdl/debug_stall.sv
hdl/wfe_ctrl.sv
hdl/core_debug_ctrl.sv
sim/tb_clk_gen.sv
sim/tb_core_debug_ctrl.sv

/* Makefile */
SIM      = verilator
TOP      = tb_core_debug_ctrl
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FLAGS    = --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^SIMULATION PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_core_debug_ctrl.sv */
// ----------------------------------------------------------
// testbench for the debug and sleep control block
// reference model, checking assertions, stimulus, watchdog
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_core_debug_ctrl;

  localparam int clk_period    = 10;
  // planned cycles per phase
  localparam int reset_cycles  = 8;
  localparam int reg_cycles    = 100;
  localparam int bp_cycles     = 130;
  localparam int run_cycles    = 250;
  localparam int margin_cycles = 200;
  localparam int limit_cycles  = reset_cycles + reg_cycles + bp_cycles + run_cycles
                                 + margin_cycles;

  logic                   clk;
  logic                   rst;
  logic                   cfg_we;
  dbg_cfg_pkg::cfg_addr_t cfg_addr;
  core_types_pkg::vaddr_t cfg_wdata;
  core_types_pkg::vaddr_t cfg_rdata;
  core_types_pkg::vaddr_t if_pc;
  core_types_pkg::vaddr_t wb_pc;
  logic                   if_valid;
  logic                   wb_valid;
  logic                   pipe_idle;
  logic                   debug_req;
  logic                   debug_resume;
  logic                   debug_stall;
  logic                   debug_stall_out;
  logic                   ext_event;
  logic                   is_wfe;
  logic                   kill;
  logic                   wfe_stall;

  // reference model state
  core_types_pkg::vaddr_t m_regs [0:8];
  core_types_pkg::vaddr_t exp_rdata;
  logic                   m_bp;
  logic                   m_dbg;
  logic                   m_ev_q;
  logic                   m_wfe_q;
  logic                   m_hold;
  logic                   m_wfe;
  logic                   hit_now;
  logic                   ev_rise_m;
  logic                   wfe_rise_m;
  logic                   hit_guard;
  logic                   quiet_guard;
  logic                   ev_sleep_guard;
  logic                   early_guard;

  int          assert_errors = 0;
  int          wait_errors = 0;
  logic [31:0] rng_state = 32'd21;

  tb_clk_gen u_clk_gen (.clk(clk));

  core_debug_ctrl uut (
    .clk(clk), .rst(rst),
    .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
    .if_pc(if_pc), .if_valid(if_valid), .wb_pc(wb_pc), .wb_valid(wb_valid),
    .pipe_idle(pipe_idle), .debug_req(debug_req), .debug_resume(debug_resume),
    .debug_stall(debug_stall), .debug_stall_out(debug_stall_out),
    .ext_event(ext_event), .is_wfe(is_wfe), .kill(kill), .wfe_stall(wfe_stall)
  );

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------
  always_comb begin
    exp_rdata = '0;
    if (cfg_addr <= 4'd8) begin
      exp_rdata = m_regs[cfg_addr];
    end
  end

  // enable bits live in the low byte of index 8
  always_comb begin
    hit_now = 1'b0;
    for (int i = 0; i < dbg_cfg_pkg::n_bp_slots; i++) begin
      if (if_valid && m_regs[8][i] && (if_pc == m_regs[i])) begin
        hit_now = 1'b1;
      end
      if (wb_valid && m_regs[8][4 + i] && (wb_pc == m_regs[4 + i])) begin
        hit_now = 1'b1;
      end
    end
  end

  assign ev_rise_m      = ext_event && !m_ev_q;
  assign wfe_rise_m     = is_wfe && !m_wfe_q;
  assign hit_guard      = hit_now && !debug_stall && !debug_req && !m_bp;
  assign quiet_guard    = !hit_now && !debug_stall && !debug_req && !m_bp;
  assign ev_sleep_guard = wfe_stall && !m_hold && ev_rise_m && !wfe_rise_m && !kill;
  assign early_guard    = !wfe_stall && m_hold && wfe_rise_m && !ev_rise_m;

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 9; i++) begin
        m_regs[i] <= '0;
      end
      m_bp    <= 1'b0;
      m_dbg   <= 1'b0;
      m_ev_q  <= 1'b0;
      m_wfe_q <= 1'b0;
      m_hold  <= 1'b0;
      m_wfe   <= 1'b0;
    end else begin
      if (cfg_we && (cfg_addr < 4'd8)) begin
        m_regs[cfg_addr] <= cfg_wdata;
      end else if (cfg_we && (cfg_addr == 4'd8)) begin
        m_regs[8] <= core_types_pkg::vaddr_t'(cfg_wdata[7:0]);
      end
      m_bp <= hit_now;
      if (!m_dbg) begin
        m_dbg <= m_bp || debug_req;
      end else if (debug_resume) begin
        m_dbg <= 1'b0;
      end
      m_ev_q  <= ext_event;
      m_wfe_q <= is_wfe;
      if (m_wfe && m_hold) begin
        m_hold <= 1'b0;
      end else if (ev_rise_m && !wfe_rise_m) begin
        m_hold <= 1'b1;
      end
      if (!m_wfe) begin
        m_wfe <= wfe_rise_m && !ev_rise_m;
      end else if (m_hold || kill) begin
        m_wfe <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  task automatic flag_error(input string msg);
    assert_errors++;
    $display("** Error at %0t ns: %s", $time, msg);
  endtask

  a_reset_state: assert property (@(posedge clk) disable iff (rst)
    $past(rst) |-> !debug_stall && !debug_stall_out && !wfe_stall && (cfg_rdata == '0))
    else flag_error("outputs not cleared after reset");
  a_rdata: assert property (@(posedge clk) disable iff (rst) cfg_rdata == exp_rdata)
    else flag_error("cfg_rdata differs from register model");
  a_high_addr: assert property (@(posedge clk) disable iff (rst)
    (cfg_addr > 4'd8) |-> (cfg_rdata == '0)) else flag_error("unmapped index not zero");
  a_dbg_model: assert property (@(posedge clk) disable iff (rst) debug_stall == m_dbg)
    else flag_error("debug_stall differs from model");
  a_hit_latency: assert property (@(posedge clk) disable iff (rst)
    $past(hit_guard, 2) |-> debug_stall && !$past(debug_stall))
    else flag_error("breakpoint hit did not stall 2 cycles later");
  a_no_false_hit: assert property (@(posedge clk) disable iff (rst)
    $past(quiet_guard, 2) && !$past(debug_req) |-> !debug_stall)
    else flag_error("stall without an enabled hit");
  a_resume: assert property (@(posedge clk) disable iff (rst)
    $past(debug_stall) && $past(debug_resume) |-> !debug_stall)
    else flag_error("resume did not clear debug_stall");
  a_req: assert property (@(posedge clk) disable iff (rst)
    !$past(debug_stall) && $past(debug_req) |-> debug_stall)
    else flag_error("debug_req did not stall 1 cycle later");
  a_stall_out: assert property (@(posedge clk) disable iff (rst)
    debug_stall_out == (m_dbg && pipe_idle)) else flag_error("debug_stall_out wrong");
  a_wfe_model: assert property (@(posedge clk) disable iff (rst) wfe_stall == m_wfe)
    else flag_error("wfe_stall differs from model");
  a_wfe_enter: assert property (@(posedge clk) disable iff (rst)
    !$past(wfe_stall) && $past(wfe_rise_m) && !$past(ev_rise_m) |-> wfe_stall)
    else flag_error("wait did not raise wfe_stall");
  a_kill_wake: assert property (@(posedge clk) disable iff (rst)
    $past(wfe_stall) && $past(kill) |-> !wfe_stall) else flag_error("kill did not wake");
  a_event_wake: assert property (@(posedge clk) disable iff (rst)
    $past(ev_sleep_guard, 2) |-> !wfe_stall && $past(wfe_stall))
    else flag_error("event did not wake 2 cycles later");
  a_early_event: assert property (@(posedge clk) disable iff (rst)
    $past(early_guard, 2) |-> !wfe_stall && $past(wfe_stall))
    else flag_error("early event did not give a one-cycle sleep");

  // ----------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic random_word(output logic [31:0] w);
    rng_state = xorshift32(rng_state);
    w = rng_state;
  endtask

  task automatic random_vaddr(output core_types_pkg::vaddr_t v);
    logic [31:0] lo;
    logic [31:0] hi;
    random_word(lo);
    random_word(hi);
    v = {hi[core_types_pkg::vaddr_w-33:0], lo};
  endtask

  // advance to just after the next rising edge
  task automatic step();
    logic [31:0] w;
    @(posedge clk);
    #1;
    random_word(w);
    pipe_idle = w[3];
  endtask

  task automatic cfg_write(input int a, input core_types_pkg::vaddr_t d);
    cfg_we    = 1'b1;
    cfg_addr  = dbg_cfg_pkg::cfg_addr_t'(a);
    cfg_wdata = d;
    step();
    cfg_we    = 1'b0;
  endtask

  task automatic cfg_read(input int a);
    cfg_addr = dbg_cfg_pkg::cfg_addr_t'(a);
    step();
  endtask

  task automatic wait_for_stall(input logic sleep, input logic level, input int max_cycles);
    int n;
    n = 0;
    while (((sleep ? wfe_stall : debug_stall) != level) && (n < max_cycles)) begin
      step();
      n++;
    end
    if ((sleep ? wfe_stall : debug_stall) != level) begin
      wait_errors++;
      $display("%s stall did not reach %0b within %0d cycles",
               sleep ? "sleep" : "debug", level, max_cycles);
    end
  endtask

  // one pc presented for one cycle, resumed if it stalls
  task automatic bp_case(input logic use_wb, input core_types_pkg::vaddr_t pc,
                         input logic valid, input logic expect_hit);
    if (use_wb) begin
      wb_pc    = pc;
      wb_valid = valid;
    end else begin
      if_pc    = pc;
      if_valid = valid;
    end
    step();
    if_valid = 1'b0;
    wb_valid = 1'b0;
    if (expect_hit) begin
      wait_for_stall(1'b0, 1'b1, 4);
      debug_resume = 1'b1;
      step();
      debug_resume = 1'b0;
      wait_for_stall(1'b0, 1'b0, 2);
    end else begin
      repeat (4) step();
    end
  endtask

  // ----------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------
  initial begin : stimulus
    core_types_pkg::vaddr_t v;
    core_types_pkg::vaddr_t slots [0:7];
    logic [31:0]            w;
    rst          = 1'b1;
    cfg_we       = 1'b0;
    cfg_addr     = '0;
    cfg_wdata    = '0;
    if_pc        = '0;
    wb_pc        = '0;
    if_valid     = 1'b0;
    wb_valid     = 1'b0;
    pipe_idle    = 1'b0;
    debug_req    = 1'b0;
    debug_resume = 1'b0;
    ext_event    = 1'b0;
    is_wfe       = 1'b0;
    kill         = 1'b0;
    repeat (reset_cycles) step();
    rst = 1'b0;

    for (int a = 0; a < 16; a++) cfg_read(a);
    repeat (3) begin
      for (int a = 0; a < 9; a++) begin
        random_vaddr(v);
        cfg_write(a, v);
      end
    end
    for (int a = 0; a < 16; a++) cfg_read(a);
    for (int a = 9; a < 16; a++) begin
      random_vaddr(v);
      cfg_write(a, v);
    end
    for (int a = 0; a < 16; a++) cfg_read(a);

    // slots 0..2 of each stage enabled, slot 3 off
    for (int a = 0; a < 8; a++) begin
      random_vaddr(slots[a]);
      cfg_write(a, slots[a]);
    end
    cfg_write(8, core_types_pkg::vaddr_t'(8'h77));
    for (int i = 0; i < 3; i++) begin
      bp_case(1'b0, slots[i], 1'b1, 1'b1);
      bp_case(1'b1, slots[4 + i], 1'b1, 1'b1);
    end
    bp_case(1'b0, slots[3], 1'b1, 1'b0);
    bp_case(1'b1, slots[7], 1'b1, 1'b0);
    bp_case(1'b0, slots[0], 1'b0, 1'b0);
    bp_case(1'b1, slots[4], 1'b0, 1'b0);
    bp_case(1'b0, slots[1] ^ core_types_pkg::vaddr_t'(1), 1'b1, 1'b0);
    bp_case(1'b1, slots[5] ^ core_types_pkg::vaddr_t'(1), 1'b1, 1'b0);
    cfg_write(8, core_types_pkg::vaddr_t'(8'hff));
    bp_case(1'b0, slots[3], 1'b1, 1'b1);
    bp_case(1'b1, slots[7], 1'b1, 1'b1);

    // external request, a second one while stalled, resume while running
    debug_req = 1'b1;
    step();
    debug_req = 1'b0;
    wait_for_stall(1'b0, 1'b1, 2);
    debug_req = 1'b1;
    step();
    debug_req = 1'b0;
    repeat (4) step();
    debug_resume = 1'b1;
    step();
    debug_resume = 1'b0;
    wait_for_stall(1'b0, 1'b0, 2);
    debug_resume = 1'b1;
    step();
    debug_resume = 1'b0;
    repeat (2) step();

    // sleep woken by event, then by kill
    is_wfe = 1'b1;
    step();
    is_wfe = 1'b0;
    wait_for_stall(1'b1, 1'b1, 2);
    repeat (3) step();
    ext_event = 1'b1;
    step();
    ext_event = 1'b0;
    wait_for_stall(1'b1, 1'b0, 3);
    is_wfe = 1'b1;
    step();
    is_wfe = 1'b0;
    wait_for_stall(1'b1, 1'b1, 2);
    repeat (2) step();
    kill = 1'b1;
    step();
    kill = 1'b0;
    wait_for_stall(1'b1, 1'b0, 2);
    // event ahead of the wait
    ext_event = 1'b1;
    step();
    ext_event = 1'b0;
    repeat (2) step();
    is_wfe = 1'b1;
    step();
    is_wfe = 1'b0;
    repeat (4) step();

    // mixed random traffic, writes limited to enables and unmapped indices
    repeat (200) begin
      random_word(w);
      random_vaddr(cfg_wdata);
      cfg_we       = w[0] && w[1] && w[2];
      cfg_addr     = {1'b1, w[6:4]};
      if_pc        = w[10] ? slots[w[9:8]] : cfg_wdata;
      wb_pc        = w[27] ? slots[4 + w[26:25]] : ~cfg_wdata;
      if_valid     = w[23];
      wb_valid     = w[24];
      is_wfe       = w[11] && w[12];
      ext_event    = w[13] && w[14];
      kill         = w[15] && w[16] && w[17];
      debug_req    = w[18] && w[19] && w[20];
      debug_resume = w[21] && w[22];
      step();
    end
    cfg_we = 1'b0;
    repeat (3) step();

    $display("checks done: %0d assertion errors, %0d wait errors", assert_errors, wait_errors);
    if ((assert_errors == 0) && (wait_errors == 0)) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(limit_cycles * clk_period);
    $display("watchdog expired after %0d cycles, the run did not finish", limit_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
// ----------------------------------------------------------
// free-running testbench clock, 10 ns period
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk
);

  localparam int half_period = 5;

  initial begin
    clk = 1'b0;
  end

  always #(half_period) clk = ~clk;

endmodule

`default_nettype wire

/* hdl/core_debug_ctrl.sv */
// ----------------------------------------------------------
// debug and sleep control top level
// breakpoint regs, matcher, debug stall fsm, wfe control
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module core_debug_ctrl (
  input  wire logic                   clk,
  input  wire logic                   rst,
  // config port
  input  wire logic                   cfg_we,
  input  wire dbg_cfg_pkg::cfg_addr_t cfg_addr,
  input  wire core_types_pkg::vaddr_t cfg_wdata,
  output      core_types_pkg::vaddr_t cfg_rdata,
  // pipeline observation
  input  wire core_types_pkg::vaddr_t if_pc,
  input  wire logic                   if_valid,
  input  wire core_types_pkg::vaddr_t wb_pc,
  input  wire logic                   wb_valid,
  input  wire logic                   pipe_idle,
  // debug control
  input  wire logic                   debug_req,
  input  wire logic                   debug_resume,
  output      logic                   debug_stall,
  output      logic                   debug_stall_out,
  // sleep control
  input  wire logic                   ext_event,
  input  wire logic                   is_wfe,
  input  wire logic                   kill,
  output      logic                   wfe_stall
);

  core_types_pkg::vaddr_t [dbg_cfg_pkg::n_bp_slots-1:0] if_bp_pc;
  core_types_pkg::vaddr_t [dbg_cfg_pkg::n_bp_slots-1:0] wb_bp_pc;
  dbg_cfg_pkg::bp_en_t                                  if_bp_en;
  dbg_cfg_pkg::bp_en_t                                  wb_bp_en;
  logic                                                 bp_stall;

  bp_regs u_bp_regs (
    .clk      (clk),
    .rst      (rst),
    .cfg_we   (cfg_we),
    .cfg_addr (cfg_addr),
    .cfg_wdata(cfg_wdata),
    .cfg_rdata(cfg_rdata),
    .if_bp_pc (if_bp_pc),
    .wb_bp_pc (wb_bp_pc),
    .if_bp_en (if_bp_en),
    .wb_bp_en (wb_bp_en)
  );

  bp_match u_bp_match (
    .clk     (clk),
    .rst     (rst),
    .if_pc   (if_pc),
    .wb_pc   (wb_pc),
    .if_valid(if_valid),
    .wb_valid(wb_valid),
    .if_bp_pc(if_bp_pc),
    .wb_bp_pc(wb_bp_pc),
    .if_bp_en(if_bp_en),
    .wb_bp_en(wb_bp_en),
    .bp_stall(bp_stall)
  );

  debug_stall u_debug_stall (
    .clk            (clk),
    .rst            (rst),
    .bp_stall       (bp_stall),
    .debug_req      (debug_req),
    .debug_resume   (debug_resume),
    .pipe_idle      (pipe_idle),
    .debug_stall    (debug_stall),
    .debug_stall_out(debug_stall_out)
  );

  // independent of the breakpoint path
  wfe_ctrl u_wfe_ctrl (
    .clk      (clk),
    .rst      (rst),
    .ext_event(ext_event),
    .is_wfe   (is_wfe),
    .kill     (kill),
    .wfe_stall(wfe_stall)
  );

endmodule

`default_nettype wire

/* hdl/wfe_ctrl.sv */
// ----------------------------------------------------------
// wait-for-event sleep control
// edge detectors, event hold, sleep stall
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module wfe_ctrl (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic ext_event,
  input  wire logic is_wfe,
  input  wire logic kill,
  output      logic wfe_stall
);

  logic ev_q;
  logic wfe_q;
  logic ev_rise;
  logic wfe_rise;
  logic ev_hold;

  // ----------------------------------------------------------
  // edge detection
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      ev_q  <= 1'b0;
      wfe_q <= 1'b0;
    end else begin
      ev_q  <= ext_event;
      wfe_q <= is_wfe;
    end
  end

  assign ev_rise  = ext_event && !ev_q;
  assign wfe_rise = is_wfe && !wfe_q;

  // ----------------------------------------------------------
  // event hold and sleep stall
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      ev_hold   <= 1'b0;
      wfe_stall <= 1'b0;
    end else begin
      // an event ahead of the wait is remembered
      if (ev_rise && !wfe_rise) begin
        ev_hold <= 1'b1;
      end
      if (wfe_stall && ev_hold) begin
        ev_hold <= 1'b0;
      end

      if (!wfe_stall) begin
        if (wfe_rise && !ev_rise) begin
          wfe_stall <= 1'b1;
        end
      end else if (ev_hold || kill) begin
        wfe_stall <= 1'b0;
      end
    end
  end

  no_sleep_on_event: assert property (@(posedge clk) disable iff (rst)
    ev_rise |=> !$rose(wfe_stall));

endmodule

`default_nettype wire

/* hdl/debug_stall.sv */
// ----------------------------------------------------------
// debug run/stalled fsm and stall-out report
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module debug_stall (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic bp_stall,
  input  wire logic debug_req,
  input  wire logic debug_resume,
  input  wire logic pipe_idle,
  output      logic debug_stall,
  output      logic debug_stall_out
);

  dbg_cfg_pkg::stall_state_t state;

  // requests while stalled are dropped
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= dbg_cfg_pkg::st_run;
    end else begin
      case (state)
        dbg_cfg_pkg::st_run: begin
          if (bp_stall || debug_req) begin
            state <= dbg_cfg_pkg::st_stalled;
          end
        end
        dbg_cfg_pkg::st_stalled: begin
          if (debug_resume) begin
            state <= dbg_cfg_pkg::st_run;
          end
        end
        default: state <= dbg_cfg_pkg::st_run;
      endcase
    end
  end

  assign debug_stall = (state == dbg_cfg_pkg::st_stalled);

  // stalled only counts once the pipeline has drained
  assign debug_stall_out = debug_stall && pipe_idle;

  // entering the stall needs a breakpoint or a request
  stall_needs_cause: assert property (@(posedge clk) disable iff (rst)
    $rose(debug_stall) |-> $past(bp_stall || debug_req));

endmodule

`default_nettype wire

/* hdl/bp_match.sv */
// ----------------------------------------------------------
// fetch and writeback pc breakpoint compare
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bp_match (
  input  wire logic                                                    clk,
  input  wire logic                                                    rst,
  input  wire core_types_pkg::vaddr_t                                  if_pc,
  input  wire core_types_pkg::vaddr_t                                  wb_pc,
  input  wire logic                                                    if_valid,
  input  wire logic                                                    wb_valid,
  input  wire core_types_pkg::vaddr_t [dbg_cfg_pkg::n_bp_slots-1:0] if_bp_pc,
  input  wire core_types_pkg::vaddr_t [dbg_cfg_pkg::n_bp_slots-1:0] wb_bp_pc,
  input  wire dbg_cfg_pkg::bp_en_t                                     if_bp_en,
  input  wire dbg_cfg_pkg::bp_en_t                                     wb_bp_en,
  output      logic                                                    bp_stall
);

  logic if_hit;
  logic wb_hit;
  logic match;

  // any enabled slot equal to pc
  function automatic logic slot_hit(
    input core_types_pkg::vaddr_t                                  pc,
    input core_types_pkg::vaddr_t [dbg_cfg_pkg::n_bp_slots-1:0] slots,
    input dbg_cfg_pkg::bp_en_t                                     en
  );
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < dbg_cfg_pkg::n_bp_slots; i++) begin
      if (en[i] && (slots[i] == pc)) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  assign if_hit = slot_hit(if_pc, if_bp_pc, if_bp_en);
  assign wb_hit = slot_hit(wb_pc, wb_bp_pc, wb_bp_en);
  assign match  = (if_valid && if_hit) || (wb_valid && wb_hit);

  // one cycle pulse per matching cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      bp_stall <= 1'b0;
    end else begin
      bp_stall <= match;
    end
  end

  // a stall needs a valid stage with at least one enabled slot
  bp_stall_needs_enabled_slot: assert property (@(posedge clk) disable iff (rst)
    bp_stall |-> $past((if_valid && (if_bp_en != '0)) || (wb_valid && (wb_bp_en != '0))));

endmodule

`default_nettype wire

/* hdl/bp_regs.sv */
// ----------------------------------------------------------
// breakpoint slot and enable registers
// write decode and combinational read-back
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bp_regs (
  input  wire logic                                                    clk,
  input  wire logic                                                    rst,
  input  wire logic                                                    cfg_we,
  input  wire dbg_cfg_pkg::cfg_addr_t                                  cfg_addr,
  input  wire core_types_pkg::vaddr_t                                  cfg_wdata,
  output      core_types_pkg::vaddr_t                                  cfg_rdata,
  output      core_types_pkg::vaddr_t [dbg_cfg_pkg::n_bp_slots-1:0] if_bp_pc,
  output      core_types_pkg::vaddr_t [dbg_cfg_pkg::n_bp_slots-1:0] wb_bp_pc,
  output      dbg_cfg_pkg::bp_en_t                                     if_bp_en,
  output      dbg_cfg_pkg::bp_en_t                                     wb_bp_en
);

  logic       sel_if;
  logic       sel_wb;
  logic       sel_en;
  logic [1:0] slot;

  // four slots per stage, low two address bits pick the slot
  assign slot   = cfg_addr[1:0];
  assign sel_if = (cfg_addr[3:2] == dbg_cfg_pkg::addr_if_bp_base[3:2]);
  assign sel_wb = (cfg_addr[3:2] == dbg_cfg_pkg::addr_wb_bp_base[3:2]);
  assign sel_en = (cfg_addr == dbg_cfg_pkg::addr_bp_en);

  always_ff @(posedge clk) begin
    if (rst) begin
      if_bp_pc <= '0;
      wb_bp_pc <= '0;
      if_bp_en <= '0;
      wb_bp_en <= '0;
    end else if (cfg_we) begin
      if (sel_if) begin
        if_bp_pc[slot] <= cfg_wdata;
      end
      if (sel_wb) begin
        wb_bp_pc[slot] <= cfg_wdata;
      end
      if (sel_en) begin
        if_bp_en <= cfg_wdata[dbg_cfg_pkg::n_bp_slots-1:0];
        wb_bp_en <= cfg_wdata[2*dbg_cfg_pkg::n_bp_slots-1:dbg_cfg_pkg::n_bp_slots];
      end
    end
  end

  // unmapped indices read as zero
  always_comb begin
    cfg_rdata = '0;
    if (sel_if) begin
      cfg_rdata = if_bp_pc[slot];
    end else if (sel_wb) begin
      cfg_rdata = wb_bp_pc[slot];
    end else if (sel_en) begin
      cfg_rdata = core_types_pkg::vaddr_t'({wb_bp_en, if_bp_en});
    end
  end

  cfg_addr_known: assert property (@(posedge clk) disable iff (rst)
    cfg_we |-> !$isunknown(cfg_addr));

endmodule

`default_nettype wire

/* hdl/dbg_cfg_pkg.sv */
// ----------------------------------------------------------
// breakpoint slot count and register map
// enable register layout, debug stall state type
// ----------------------------------------------------------
`default_nettype none

package dbg_cfg_pkg;

  // slots per pipeline stage
  localparam int n_bp_slots = 4;

  // one enable bit per slot
  typedef logic [n_bp_slots-1:0] bp_en_t;

  // config register index
  typedef logic [3:0] cfg_addr_t;

  // ----------------------------------------------------------
  // register map
  // ----------------------------------------------------------

  // fetch slots at 0..3
  localparam cfg_addr_t addr_if_bp_base = 4'd0;
  // writeback slots at 4..7
  localparam cfg_addr_t addr_wb_bp_base = 4'd4;
  // enables, fetch in [3:0], writeback in [7:4]
  localparam cfg_addr_t addr_bp_en = 4'd8;

  // ----------------------------------------------------------
  // debug stall fsm
  // ----------------------------------------------------------

  typedef enum logic {
    st_run,
    st_stalled
  } stall_state_t;

endpackage

`default_nettype wire

/* hdl/core_types_pkg.sv */
// ----------------------------------------------------------
// widths of the observed core
// virtual program counter type
// ----------------------------------------------------------
`default_nettype none

package core_types_pkg;

  // ----------------------------------------------------------
  // address widths
  // ----------------------------------------------------------

  // sv39 virtual address space
  localparam int vaddr_w = 39;

  // ----------------------------------------------------------
  // vector types
  // ----------------------------------------------------------

  // fetch and writeback pc, also the config data path
  typedef logic [vaddr_w-1:0] vaddr_t;

endpackage

`default_nettype wire
